/* data_mem_subsys.f */
lsu_pkg.sv
mem_access_unit.sv
bus_decoder.sv
data_sram.sv
io_regs.sv
data_mem_subsys.sv
tb_checker.sv
tb_data_mem_subsys.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with verilator, runs it and looks for the pass line in the log.
verilator --binary --timing --assert -Wno-fatal --top-module tb_data_mem_subsys \
  -f data_mem_subsys.f -o tb_sim > build.log 2>&1 \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  && grep -q "STATUS: PASS" sim.log \
  && echo "simulation passed" \
  || { cat sim.log 2>/dev/null; echo "simulation failed, see build.log and sim.log"; exit 1; }

/* tb_data_mem_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_data_mem_subsys;
  import lsu_pkg::*;

  localparam int unsigned sram_words = 256;
  localparam int wait_limit = 64;
  localparam logic [xlen-1:0] gpio_pattern = 32'hA5C3_0F96;

  logic            clk;
  logic            anrst;
  logic            i_nrst;
  logic            i_valid;
  logic            o_ready;
  logic [xlen-1:0] i_addr;
  logic [xlen-1:0] i_wdata;
  logic            i_we;
  logic [2:0]      i_funct;
  logic            o_rvalid;
  logic            i_rready;
  logic [xlen-1:0] o_rdata;
  logic [xlen-1:0] i_gpio;
  logic [xlen-1:0] o_gpio;
  logic [xlen-1:0] exp_rdata;
  logic [xlen-1:0] exp_gpio;
  int              checker_errors;
  int              outstanding;
  int              timeouts = 0;
  logic [7:0]      lfsr = 8'd59;

  logic            tab_clr[$];
  logic            tab_we[$];
  logic [2:0]      tab_funct[$];
  logic [xlen-1:0] tab_addr[$];
  logic [xlen-1:0] tab_wdata[$];
  logic [xlen-1:0] tab_rdata[$];
  logic [xlen-1:0] tab_gpio[$];

  data_mem_subsys #(.sram_words(sram_words)) i_data_mem_subsys (
    .clk, .anrst, .i_nrst, .i_valid, .o_ready, .i_addr, .i_wdata, .i_we, .i_funct,
    .o_rvalid, .i_rready, .o_rdata, .i_gpio, .o_gpio
  );

  tb_checker i_checker (
    .clk, .anrst, .i_nrst, .i_valid, .i_ready(o_ready), .i_rvalid(o_rvalid), .i_rready,
    .i_rdata(o_rdata), .i_gpio(o_gpio), .i_exp_rdata(exp_rdata), .i_exp_gpio(exp_gpio),
    .o_errors(checker_errors), .o_outstanding(outstanding)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // 8-bit fibonacci lfsr, taps 8 6 5 4.
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    lfsr_next = {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic rand_bit(output logic b);
    b = lfsr[7];
    lfsr = lfsr_next(lfsr);
  endtask

  task automatic add_entry(input logic clr, input logic we, input logic [2:0] funct,
                           input logic [xlen-1:0] addr, input logic [xlen-1:0] wdata,
                           input logic [xlen-1:0] rdata, input logic [xlen-1:0] gpio);
    tab_clr.push_back(clr);
    tab_we.push_back(we);
    tab_funct.push_back(funct);
    tab_addr.push_back(addr);
    tab_wdata.push_back(wdata);
    tab_rdata.push_back(rdata);
    tab_gpio.push_back(gpio);
  endtask

  // stores reuse the load codes for their width. the last column is o_gpio after the entry.
  task automatic fill_table();
    //        clr   we    funct      addr           wdata          rdata          gpio
    add_entry(1'b0, 1'b1, funct_lw,  32'h00000010, 32'h12345678, 32'h00000000, 32'h00000000);
    add_entry(1'b0, 1'b0, funct_lw,  32'h00000010, 32'h00000000, 32'h12345678, 32'h00000000);
    add_entry(1'b0, 1'b1, funct_lw,  32'h00000020, 32'h11223344, 32'h00000000, 32'h00000000);
    add_entry(1'b0, 1'b1, funct_lb,  32'h00000021, 32'h000000F5, 32'h00000000, 32'h00000000);
    add_entry(1'b0, 1'b1, funct_lh,  32'h00000022, 32'h00008A7B, 32'h00000000, 32'h00000000);
    add_entry(1'b0, 1'b0, funct_lw,  32'h00000020, 32'h00000000, 32'h8A7BF544, 32'h00000000);
    add_entry(1'b0, 1'b0, funct_lb,  32'h00000021, 32'h00000000, 32'hFFFFFFF5, 32'h00000000);
    add_entry(1'b0, 1'b0, funct_lbu, 32'h00000021, 32'h00000000, 32'h000000F5, 32'h00000000);
    add_entry(1'b0, 1'b0, funct_lb,  32'h00000020, 32'h00000000, 32'h00000044, 32'h00000000);
    add_entry(1'b0, 1'b0, funct_lbu, 32'h00000023, 32'h00000000, 32'h0000008A, 32'h00000000);
    add_entry(1'b0, 1'b0, funct_lh,  32'h00000022, 32'h00000000, 32'hFFFF8A7B, 32'h00000000);
    add_entry(1'b0, 1'b0, funct_lhu, 32'h00000022, 32'h00000000, 32'h00008A7B, 32'h00000000);
    add_entry(1'b0, 1'b0, funct_lh,  32'h00000020, 32'h00000000, 32'hFFFFF544, 32'h00000000);
    add_entry(1'b0, 1'b1, funct_lw,  32'h10000000, 32'hDEADBEEF, 32'h00000000, 32'hDEADBEEF);
    add_entry(1'b0, 1'b1, funct_lb,  32'h10000002, 32'h00000055, 32'h00000000, 32'hDE55BEEF);
    add_entry(1'b0, 1'b1, funct_lh,  32'h10000000, 32'h00001234, 32'h00000000, 32'hDE551234);
    add_entry(1'b0, 1'b0, funct_lw,  32'h10000000, 32'h00000000, 32'hDE551234, 32'hDE551234);
    add_entry(1'b0, 1'b0, funct_lw,  32'h10000004, 32'h00000000, gpio_pattern, 32'hDE551234);
    add_entry(1'b0, 1'b1, funct_lw,  32'h10000008, 32'hCAFEF00D, 32'h00000000, 32'hDE551234);
    add_entry(1'b0, 1'b0, funct_lhu, 32'h1000000A, 32'h00000000, 32'h0000CAFE, 32'hDE551234);
    add_entry(1'b0, 1'b0, funct_lw,  32'h20000000, 32'h00000000, 32'h00000000, 32'hDE551234);
    add_entry(1'b0, 1'b0, funct_lw,  32'h00000410, 32'h00000000, 32'h00000000, 32'hDE551234);
    add_entry(1'b1, 1'b0, funct_lw,  32'h00000010, 32'h00000000, 32'h12345678, 32'h00000000);
    add_entry(1'b0, 1'b0, funct_lw,  32'h10000000, 32'h00000000, 32'h00000000, 32'h00000000);
  endtask

  task automatic wait_ready(input int n, output logic ok);
    int waits;
    waits = 0;
    while (!o_ready && waits < wait_limit) begin
      @(negedge clk);
      waits++;
    end
    ok = o_ready;
    if (!ok) $display("timeout: entry %0d was never accepted, o_ready stayed low", n);
  endtask

  task automatic wait_rvalid(input int n, output logic ok);
    int waits;
    waits = 0;
    while (!o_rvalid && waits < wait_limit) begin
      @(negedge clk);
      waits++;
    end
    ok = o_rvalid;
    if (!ok) $display("timeout: entry %0d got no response, o_rvalid never rose", n);
  endtask

  // i_rready is withheld at random until the lfsr hands out a one.
  task automatic wait_take(input int n, output logic ok);
    int   waits;
    logic b;
    waits = 0;
    rand_bit(b);
    i_rready = b;
    while (!i_rready && waits < wait_limit) begin
      @(negedge clk);
      rand_bit(b);
      i_rready = b;
      waits++;
    end
    ok = i_rready;
    if (ok) begin
      @(negedge clk);  // the response was taken on the edge just passed.
      i_rready = 1'b0;
    end else begin
      $display("timeout: entry %0d response was never taken, i_rready stayed low", n);
    end
  endtask

  task automatic run_entry(input int n, output logic ok);
    i_valid   = 1'b1;
    i_we      = tab_we[n];
    i_funct   = tab_funct[n];
    i_addr    = tab_addr[n];
    i_wdata   = tab_wdata[n];
    exp_rdata = tab_rdata[n];
    exp_gpio  = tab_gpio[n];
    wait_ready(n, ok);
    if (ok) begin
      @(negedge clk);
      i_valid = 1'b0;
      wait_rvalid(n, ok);
    end
    if (ok) wait_take(n, ok);
    i_valid = 1'b0;
  endtask

  task automatic finish_run();
    int total;
    total = checker_errors + timeouts + outstanding;
    $display("errors: %0d check errors, %0d timeouts, %0d responses missing",
             checker_errors, timeouts, outstanding);
    if (total == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  initial begin
    logic ok;
    anrst     = 1'b0;
    i_nrst    = 1'b1;
    i_valid   = 1'b0;
    i_addr    = '0;
    i_wdata   = '0;
    i_we      = 1'b0;
    i_funct   = funct_lw;
    i_rready  = 1'b0;
    i_gpio    = gpio_pattern;
    exp_rdata = '0;
    exp_gpio  = '0;
    fill_table();
    repeat (4) @(posedge clk);
    @(negedge clk);
    anrst = 1'b1;
    for (int n = 0; n < tab_we.size(); n++) begin
      @(negedge clk);
      if (tab_clr[n]) begin
        i_nrst = 1'b0;  // one edge of soft clear.
        @(negedge clk);
        i_nrst = 1'b1;
      end
      run_entry(n, ok);
      if (!ok) begin
        timeouts++;
        break;
      end
    end
    repeat (2) @(negedge clk);
    finish_run();
  end

endmodule

`default_nettype wire

/* tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input  wire logic                      clk,
  input  wire logic                      anrst,
  input  wire logic                      i_nrst,
  input  wire logic                      i_valid,
  input  wire logic                      i_ready,
  input  wire logic                      i_rvalid,
  input  wire logic                      i_rready,
  input  wire logic [lsu_pkg::xlen-1:0]  i_rdata,
  input  wire logic [lsu_pkg::xlen-1:0]  i_gpio,
  input  wire logic [lsu_pkg::xlen-1:0]  i_exp_rdata,
  input  wire logic [lsu_pkg::xlen-1:0]  i_exp_gpio,
  output int                             o_errors,
  output int                             o_outstanding
);
  import lsu_pkg::*;

  logic [xlen-1:0] exp_rdata_q[$];
  logic [xlen-1:0] exp_gpio_q[$];
  int              errors = 0;
  int              pending = 0;
  int              edge_cnt = 0;
  int              accept_edge = 0;
  logic            rvalid_d = 1'b0;
  logic            rready_d = 1'b0;
  logic            nrst_d = 1'b1;
  logic [xlen-1:0] rdata_d = '0;
  logic [xlen-1:0] want_rdata;
  logic [xlen-1:0] want_gpio;

  assign o_errors      = errors;
  assign o_outstanding = pending;

  task automatic report_mismatch(input string msg);
    errors++;
    $display("mismatch at %0t: %s", $time, msg);
  endtask

  task automatic report_fault(input string msg);
    errors++;
    $display("error at %0t: %s", $time, msg);
  endtask

  // every input is sampled before the dut updates on this edge.
  always @(posedge clk) begin
    if (anrst) begin
      edge_cnt++;
      if (!nrst_d) begin  // the previous edge was a soft clear.
        if (i_gpio !== '0) report_mismatch($sformatf("o_gpio is %h after soft clear", i_gpio));
        if (!i_ready) report_fault("o_ready is low after a soft clear");
        if (i_rvalid) report_fault("o_rvalid is high after a soft clear");
      end
      if (rvalid_d && !rready_d) begin
        if (!i_rvalid) begin
          report_fault("o_rvalid dropped before the response was taken");
        end else if (i_rdata !== rdata_d) begin
          report_mismatch($sformatf("o_rdata changed from %h to %h under back-pressure",
                                    rdata_d, i_rdata));
        end
      end
      if (i_ready && exp_rdata_q.size() != 0) begin
        report_fault("o_ready is high while a request is in flight");
      end
      if (i_rvalid && !rvalid_d && (edge_cnt - 1 - accept_edge) != 2) begin
        report_mismatch($sformatf("o_rvalid rose %0d edges after acceptance, expected 2",
                                  edge_cnt - 1 - accept_edge));
      end
      if (i_rvalid && exp_rdata_q.size() == 0) begin
        report_fault("o_rvalid is high with no accepted request");
      end else if (i_rvalid && i_rready) begin
        want_rdata = exp_rdata_q.pop_front();
        want_gpio  = exp_gpio_q.pop_front();
        if (i_rdata !== want_rdata) begin
          report_mismatch($sformatf("o_rdata %h, expected %h", i_rdata, want_rdata));
        end
        if (i_gpio !== want_gpio) begin
          report_mismatch($sformatf("o_gpio %h, expected %h", i_gpio, want_gpio));
        end
      end
      if (i_valid && i_ready) begin
        exp_rdata_q.push_back(i_exp_rdata);
        exp_gpio_q.push_back(i_exp_gpio);
        accept_edge = edge_cnt;
      end
      rvalid_d = i_rvalid;
      rready_d = i_rready;
      nrst_d   = i_nrst;
      rdata_d  = i_rdata;
      pending  = exp_rdata_q.size();
    end
  end

endmodule

`default_nettype wire

/* data_mem_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module data_mem_subsys #(
  parameter int unsigned sram_words = 256
) (
  input  wire logic                      clk,
  input  wire logic                      anrst,
  input  wire logic                      i_nrst,
  input  wire logic                      i_valid,
  output logic                           o_ready,
  input  wire logic [lsu_pkg::xlen-1:0]  i_addr,
  input  wire logic [lsu_pkg::xlen-1:0]  i_wdata,
  input  wire logic                      i_we,
  input  wire logic [2:0]                i_funct,
  output logic                           o_rvalid,
  input  wire logic                      i_rready,
  output logic [lsu_pkg::xlen-1:0]       o_rdata,
  input  wire logic [lsu_pkg::xlen-1:0]  i_gpio,
  output logic [lsu_pkg::xlen-1:0]       o_gpio
);
  import lsu_pkg::*;

  wire logic              bus_req, bus_we, bus_gnt, bus_data_gnt;
  wire logic [xlen-1:0]   bus_addr, bus_wdata, bus_rdata;
  wire logic [xlen/8-1:0] bus_wstrb;
  wire logic              sram_req, sram_gnt, sram_data_gnt;
  wire logic [xlen-1:0]   sram_rdata;
  wire logic              io_req, io_gnt, io_data_gnt;
  wire logic [xlen-1:0]   io_rdata;

  mem_access_unit i_mem_access_unit (
    .clk, .anrst, .i_nrst, .i_valid, .o_ready, .i_addr, .i_wdata, .i_we, .i_funct,
    .o_rvalid, .i_rready, .o_rdata,
    .o_bus_req(bus_req), .o_bus_addr(bus_addr), .o_bus_wdata(bus_wdata),
    .o_bus_wstrb(bus_wstrb), .o_bus_we(bus_we), .i_bus_gnt(bus_gnt),
    .i_bus_data_gnt(bus_data_gnt), .i_bus_rdata(bus_rdata)
  );

  bus_decoder #(.sram_words(sram_words)) i_bus_decoder (
    .clk, .anrst, .i_req(bus_req), .i_addr(bus_addr),
    .o_gnt(bus_gnt), .o_data_gnt(bus_data_gnt), .o_rdata(bus_rdata),
    .o_sram_req(sram_req), .i_sram_gnt(sram_gnt), .i_sram_data_gnt(sram_data_gnt),
    .i_sram_rdata(sram_rdata), .o_io_req(io_req), .i_io_gnt(io_gnt),
    .i_io_data_gnt(io_data_gnt), .i_io_rdata(io_rdata)
  );

  data_sram #(.sram_words(sram_words)) i_data_sram (
    .clk, .i_req(sram_req), .i_we(bus_we), .i_addr(bus_addr), .i_wdata(bus_wdata),
    .i_wstrb(bus_wstrb), .o_gnt(sram_gnt), .o_data_gnt(sram_data_gnt), .o_rdata(sram_rdata)
  );

  // the soft clear also reaches the gpio output register.
  io_regs i_io_regs (
    .clk, .anrst, .i_nrst, .i_req(io_req), .i_we(bus_we), .i_addr(bus_addr),
    .i_wdata(bus_wdata), .i_wstrb(bus_wstrb), .o_gnt(io_gnt), .o_data_gnt(io_data_gnt),
    .o_rdata(io_rdata), .i_gpio, .o_gpio
  );

endmodule

`default_nettype wire

/* io_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module io_regs (
  input  wire logic                        clk,
  input  wire logic                        anrst,
  input  wire logic                        i_nrst,
  input  wire logic                        i_req,
  input  wire logic                        i_we,
  input  wire logic [lsu_pkg::xlen-1:0]    i_addr,
  input  wire logic [lsu_pkg::xlen-1:0]    i_wdata,
  input  wire logic [lsu_pkg::xlen/8-1:0]  i_wstrb,
  output logic                             o_gnt,
  output logic                             o_data_gnt,
  output logic [lsu_pkg::xlen-1:0]         o_rdata,
  input  wire logic [lsu_pkg::xlen-1:0]    i_gpio,
  output logic [lsu_pkg::xlen-1:0]         o_gpio
);
  import lsu_pkg::*;

  logic [xlen-7:0] offset;
  logic [xlen-1:0] gpio_in;
  logic [xlen-1:0] scratch;
  logic [xlen-1:0] rd_word;

  assign offset = i_addr[xlen-5:2];
  assign o_gnt  = i_req;

  always_comb begin
    case (offset)
      io_gpio_out: rd_word = o_gpio;
      io_gpio_in:  rd_word = gpio_in;
      io_scratch:  rd_word = scratch;
      default:     rd_word = '0;
    endcase
  end

  always_ff @(posedge clk or negedge anrst) begin
    if (!anrst) begin
      o_gpio     <= '0;
      o_data_gnt <= 1'b0;
    end else if (!i_nrst) begin
      o_gpio     <= '0;
      o_data_gnt <= 1'b0;
    end else begin
      o_data_gnt <= i_req;
      for (int i = 0; i < xlen / 8; i++) begin
        if (i_req && i_we && i_wstrb[i] && offset == io_gpio_out) begin
          o_gpio[8*i +: 8] <= i_wdata[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    gpio_in <= i_gpio;  // sampled every cycle, never written.
    for (int i = 0; i < xlen / 8; i++) begin
      if (i_req && i_we && i_wstrb[i] && offset == io_scratch) scratch[8*i +: 8] <= i_wdata[8*i +: 8];
    end
    if (i_req && !i_we) o_rdata <= rd_word;
  end

endmodule

`default_nettype wire

/* data_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_sram #(
  parameter int unsigned sram_words = 256
) (
  input  wire logic                        clk,
  input  wire logic                        i_req,
  input  wire logic                        i_we,
  input  wire logic [lsu_pkg::xlen-1:0]    i_addr,
  input  wire logic [lsu_pkg::xlen-1:0]    i_wdata,
  input  wire logic [lsu_pkg::xlen/8-1:0]  i_wstrb,
  output logic                             o_gnt,
  output logic                             o_data_gnt,
  output logic [lsu_pkg::xlen-1:0]         o_rdata
);
  import lsu_pkg::*;

  localparam int unsigned idx_w = $clog2(sram_words);

  mem_word_u        mem [sram_words];
  mem_word_u        wr_word;
  logic [idx_w-1:0] word_idx;

  // the decoder has already range-checked the address.
  assign word_idx     = i_addr[idx_w+1:2];
  assign wr_word.word = i_wdata;
  assign o_gnt        = i_req;  // always ready.

  always_ff @(posedge clk) begin
    o_data_gnt <= i_req;
    if (i_req && i_we) begin
      for (int i = 0; i < xlen / 8; i++) begin
        if (i_wstrb[i]) mem[word_idx].lanes[i] <= wr_word.lanes[i];
      end
    end
    if (i_req && !i_we) o_rdata <= mem[word_idx].word;
  end

endmodule

`default_nettype wire

/* bus_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_decoder #(
  parameter int unsigned sram_words = 256
) (
  input  wire logic                      clk,
  input  wire logic                      anrst,
  input  wire logic                      i_req,
  input  wire logic [lsu_pkg::xlen-1:0]  i_addr,
  output logic                           o_gnt,
  output logic                           o_data_gnt,
  output logic [lsu_pkg::xlen-1:0]       o_rdata,
  output logic                           o_sram_req,
  input  wire logic                      i_sram_gnt,
  input  wire logic                      i_sram_data_gnt,
  input  wire logic [lsu_pkg::xlen-1:0]  i_sram_rdata,
  output logic                           o_io_req,
  input  wire logic                      i_io_gnt,
  input  wire logic                      i_io_data_gnt,
  input  wire logic [lsu_pkg::xlen-1:0]  i_io_rdata
);
  import lsu_pkg::*;

  logic sram_hit;
  logic io_hit;
  logic sel_sram;   // target of the transfer in its data phase.
  logic sel_io;
  logic unmapped_dgnt;

  // sram addresses past the array are treated as unmapped.
  assign sram_hit = (i_addr[xlen-1 -: 4] == region_sram) && (i_addr[xlen-5:2] < sram_words);
  assign io_hit   = (i_addr[xlen-1 -: 4] == region_io);

  assign o_sram_req = i_req & sram_hit;
  assign o_io_req   = i_req & io_hit;
  assign o_gnt      = sram_hit ? i_sram_gnt : (io_hit ? i_io_gnt : i_req);

  always_ff @(posedge clk or negedge anrst) begin
    if (!anrst) begin
      sel_sram      <= 1'b0;
      sel_io        <= 1'b0;
      unmapped_dgnt <= 1'b0;
    end else begin
      if (i_req && o_gnt) begin
        sel_sram <= sram_hit;
        sel_io   <= io_hit;
      end
      unmapped_dgnt <= i_req & ~sram_hit & ~io_hit;
    end
  end

  assign o_data_gnt = sel_sram ? i_sram_data_gnt : (sel_io ? i_io_data_gnt : unmapped_dgnt);
  assign o_rdata    = sel_sram ? i_sram_rdata : (sel_io ? i_io_rdata : '0);

  // only one secondary is busy at a time, in its request or its data phase.
  a_one_target : assert property (@(posedge clk) disable iff (!anrst)
    $onehot0({o_sram_req, o_io_req, i_sram_data_gnt, i_io_data_gnt}));

endmodule

`default_nettype wire

/* mem_access_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_access_unit (
  input  wire logic                      clk,
  input  wire logic                      anrst,
  input  wire logic                      i_nrst,
  input  wire logic                      i_valid,
  output logic                           o_ready,
  input  wire logic [lsu_pkg::xlen-1:0]  i_addr,
  input  wire logic [lsu_pkg::xlen-1:0]  i_wdata,
  input  wire logic                      i_we,
  input  wire logic [2:0]                i_funct,
  output logic                           o_rvalid,
  input  wire logic                      i_rready,
  output logic [lsu_pkg::xlen-1:0]       o_rdata,
  output logic                           o_bus_req,
  output logic [lsu_pkg::xlen-1:0]       o_bus_addr,
  output logic [lsu_pkg::xlen-1:0]       o_bus_wdata,
  output logic [lsu_pkg::xlen/8-1:0]     o_bus_wstrb,
  output logic                           o_bus_we,
  input  wire logic                      i_bus_gnt,
  input  wire logic                      i_bus_data_gnt,
  input  wire logic [lsu_pkg::xlen-1:0]  i_bus_rdata
);
  import lsu_pkg::*;

  logic              buf_valid;
  logic              buf_done;  // set once the bus has granted the request.
  logic              buf_we;
  logic [2:0]        buf_funct;
  logic [xlen-1:0]   buf_addr;
  logic [xlen-1:0]   buf_wdata;
  logic              accept;
  logic              taken;
  logic              resp_load;
  logic [xlen/8-1:0] wstrb;
  mem_word_u         wdata_rep;
  mem_word_u         rdata_word;
  logic [7:0]        byte_sel;
  logic [15:0]       half_sel;
  logic [xlen-1:0]   load_data;

  assign o_ready   = ~buf_valid;
  assign accept    = i_valid & o_ready;
  assign taken     = o_rvalid & i_rready;
  assign resp_load = buf_valid & buf_done & i_bus_data_gnt;

  assign o_bus_req   = buf_valid & ~buf_done;
  assign o_bus_addr  = buf_addr;
  assign o_bus_we    = buf_we;
  assign o_bus_wdata = wdata_rep.word;
  assign o_bus_wstrb = wstrb;

  // strobes follow the access width and the low address bits.
  always_comb begin
    case (buf_funct[1:0])
      2'b00:   wstrb = 4'b0001 << buf_addr[1:0];
      2'b01:   wstrb = 4'b0011 << buf_addr[1:0];
      default: wstrb = 4'b1111;
    endcase
    if (!buf_we) wstrb = '0;
  end

  // store data is copied to every lane so the strobes pick the right one.
  always_comb begin
    wdata_rep.word = buf_wdata;
    if (buf_funct[1:0] == 2'b00) begin
      for (int i = 0; i < xlen / 8; i++) wdata_rep.lanes[i] = buf_wdata[7:0];
    end else if (buf_funct[1:0] == 2'b01) begin
      wdata_rep.word = {2{buf_wdata[15:0]}};
    end
  end

  assign rdata_word.word = i_bus_rdata;
  assign byte_sel = rdata_word.lanes[buf_addr[1:0]];
  assign half_sel = rdata_word.word[16*buf_addr[1] +: 16];

  always_comb begin
    case (buf_funct)
      funct_lb:  load_data = {{(xlen-8){byte_sel[7]}}, byte_sel};
      funct_lbu: load_data = {{(xlen-8){1'b0}}, byte_sel};
      funct_lh:  load_data = {{(xlen-16){half_sel[15]}}, half_sel};
      funct_lhu: load_data = {{(xlen-16){1'b0}}, half_sel};
      default:   load_data = i_bus_rdata;  // funct_lw.
    endcase
  end

  always_ff @(posedge clk or negedge anrst) begin
    if (!anrst) begin
      buf_valid <= 1'b0;
      buf_done  <= 1'b0;
      o_rvalid  <= 1'b0;
    end else if (!i_nrst) begin
      buf_valid <= 1'b0;
      buf_done  <= 1'b0;
      o_rvalid  <= 1'b0;
    end else begin
      if (accept) buf_valid <= 1'b1;
      else if (taken) buf_valid <= 1'b0;
      if (o_bus_req && i_bus_gnt) buf_done <= 1'b1;
      else if (taken) buf_done <= 1'b0;
      if (resp_load) o_rvalid <= 1'b1;
      else if (taken) o_rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      buf_we    <= i_we;
      buf_funct <= i_funct;
      buf_addr  <= i_addr;
      buf_wdata <= i_wdata;
    end
    if (resp_load) o_rdata <= buf_we ? '0 : load_data;  // stores answer with zero.
  end

  a_aligned : assert property (@(posedge clk) disable iff (!anrst)
    accept |-> (i_funct[1:0] == 2'b00) ||
               (i_funct[1:0] == 2'b01 && !i_addr[0]) ||
               (i_addr[1:0] == 2'b00));

  // the bus stays quiet while the response waits to be taken.
  a_bus_idle_while_pending : assert property (@(posedge clk) disable iff (!anrst)
    o_rvalid |-> !o_bus_req && !i_bus_data_gnt);

endmodule

`default_nettype wire

/* lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

  // data and address width of the core.
  localparam int unsigned xlen = 32;

  // rv32 funct3 load codes; stores reuse the low two bits for the width.
  localparam logic [2:0] funct_lb  = 3'b000;
  localparam logic [2:0] funct_lh  = 3'b001;
  localparam logic [2:0] funct_lw  = 3'b010;
  localparam logic [2:0] funct_lbu = 3'b100;
  localparam logic [2:0] funct_lhu = 3'b101;

  // address map, selected by address bits 31:28.
  localparam logic [3:0] region_sram = 4'h0;
  localparam logic [3:0] region_io   = 4'h1;

  // word offsets inside the i/o region, taken from address bits 27:2.
  localparam logic [xlen-7:0] io_gpio_out = 'd0;
  localparam logic [xlen-7:0] io_gpio_in  = 'd1;
  localparam logic [xlen-7:0] io_scratch  = 'd2;

  // one memory word, seen as a whole or as its byte lanes.
  typedef union packed {
    logic [xlen-1:0]          word;
    logic [xlen/8-1:0][7:0]   lanes;
  } mem_word_u;

endpackage

`default_nettype wire
